// File: all.f
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_bank.sv
hdl/trap_redirect.sv
hdl/machine_timer.sv
hdl/csr_unit_top.sv
sim/csr_unit_sva.sv
sim/tb_csr_unit.sv

// File: hdl/csr_bank.sv
// Machine CSR bank: masked CSR writes, counters, trap entry and return, interrupt pending
`timescale 1ns/1ps

module csr_bank
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            read_enable_i,
    input  logic            write_enable_i,
    input  csr_op_e         operation_i,
    input  logic [11:0]     address_i,
    input  logic [XLEN-1:0] data_i,
    input  logic            killed_i,
    input  logic            retire_i,
    input  logic            raise_exception_i,
    input  exc_code_e       exception_code_i,
    input  logic            machine_return_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [31:0]     instruction_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_target_i,
    input  logic [63:0]     mtime_i,
    input  logic [31:0]     irq_i,
    input  logic            interrupt_ack_i,
    output logic [XLEN-1:0] read_data_o,
    output logic            interrupt_pending_o,
    output irq_code_e       interrupt_code_o,
    output priv_e           privilege_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    logic [XLEN-1:0] mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mtval, mip;
    logic [63:0]     mcycle, minstret;
    logic [XLEN-1:0] current_val, wmask, op_result, wr_data;
    priv_e           privilege;

    assign privilege_o = privilege;
    assign mtvec_o     = mtvec;
    assign mepc_o      = mepc;

    // Current value, shared by the read port and set/clear
    always_comb begin
        case (address_i)
            CSR_MSTATUS:               current_val = mstatus;
            CSR_MISA:                  current_val = misa;
            CSR_MIE:                   current_val = mie;
            CSR_MTVEC:                 current_val = mtvec;
            CSR_MSCRATCH:              current_val = mscratch;
            CSR_MEPC:                  current_val = mepc;
            CSR_MCAUSE:                current_val = mcause;
            CSR_MTVAL:                 current_val = mtval;
            CSR_MIP:                   current_val = mip;
            CSR_MCYCLE, CSR_CYCLE:     current_val = mcycle[31:0];
            CSR_MCYCLEH, CSR_CYCLEH:   current_val = mcycle[63:32];
            CSR_MINSTRET, CSR_INSTRET: current_val = minstret[31:0];
            CSR_MINSTRETH, CSR_INSTRETH: current_val = minstret[63:32];
            CSR_TIME:                  current_val = mtime_i[31:0];
            CSR_TIMEH:                 current_val = mtime_i[63:32];
            default:                   current_val = '0;   // ID registers read zero
        endcase
    end

    assign read_data_o = read_enable_i ? current_val : '0;

    // Writable bits per register
    always_comb begin
        case (address_i)
            CSR_MSTATUS:  wmask = 32'h007E_19AA;
            CSR_MISA:     wmask = 32'h3C00_0000;
            CSR_MIE:      wmask = 32'h0000_0888;
            CSR_MTVEC:    wmask = 32'hFFFF_FFFD;   // Bit 0 kept for vectored mode
            CSR_MEPC:     wmask = 32'hFFFF_FFFC;
            CSR_MSCRATCH, CSR_MCAUSE, CSR_MTVAL, CSR_MCYCLE, CSR_MCYCLEH,
            CSR_MINSTRET, CSR_MINSTRETH: wmask = 32'hFFFF_FFFF;
            default:      wmask = '0;
        endcase
    end

    always_comb begin
        case (operation_i)
            CSR_WRITE: op_result = data_i;
            CSR_SET:   op_result = current_val | data_i;
            CSR_CLEAR: op_result = current_val & ~data_i;
            default:   op_result = current_val;
        endcase
    end

    // Bits outside the mask keep their value
    assign wr_data = (op_result & wmask) | (current_val & ~wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus   <= 32'h0000_1800;   // MPP = M
            misa      <= 32'h4000_0100;   // RV32I
            mie       <= '0;
            mtvec     <= '0;
            mscratch  <= '0;
            mepc      <= '0;
            mcause    <= '0;
            mtval     <= '0;
            mcycle    <= '0;
            minstret  <= '0;
            privilege <= PRIV_M;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (retire_i && !killed_i) begin
                minstret <= minstret + 64'd1;
            end

            if (machine_return_i) begin
                mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
                mstatus[MSTATUS_MPIE] <= 1'b1;
                privilege <= (mstatus[MSTATUS_MPP_LO +: 2] == PRIV_U) ? PRIV_U : PRIV_M;
            end else if (raise_exception_i || interrupt_ack_i) begin
                mstatus[MSTATUS_MPP_LO +: 2] <= privilege;   // Stack the trap state
                mstatus[MSTATUS_MPIE]        <= mstatus[MSTATUS_MIE];
                mstatus[MSTATUS_MIE]         <= 1'b0;
                privilege                    <= PRIV_M;
                if (raise_exception_i) begin
                    mcause <= {1'b0, {(XLEN-6){1'b0}}, exception_code_i};
                    mepc   <= (exception_code_i == ECALL_M || exception_code_i == BREAKPOINT)
                              ? pc_i : pc_i + 32'd4;
                    mtval  <= (exception_code_i == ILLEGAL_INSTRUCTION) ? instruction_i : pc_i;
                end else begin
                    mcause <= {1'b1, {(XLEN-6){1'b0}}, interrupt_code_o};
                    mepc   <= jump_i ? jump_target_i : pc_i;   // Resume where flow was going
                end
            end else if (write_enable_i && !killed_i) begin
                case (address_i)
                    CSR_MSTATUS:   mstatus         <= wr_data;
                    CSR_MISA:      misa            <= wr_data;
                    CSR_MIE:       mie             <= wr_data;
                    CSR_MTVEC:     mtvec           <= wr_data;
                    CSR_MSCRATCH:  mscratch        <= wr_data;
                    CSR_MEPC:      mepc            <= wr_data;
                    CSR_MCAUSE:    mcause          <= wr_data;
                    CSR_MTVAL:     mtval           <= wr_data;
                    CSR_MCYCLE:    mcycle[31:0]    <= wr_data;
                    CSR_MCYCLEH:   mcycle[63:32]   <= wr_data;
                    CSR_MINSTRET:  minstret[31:0]  <= wr_data;
                    CSR_MINSTRETH: minstret[63:32] <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    // Interrupt lines sampled into mip, then qualified into the pending flag
    always_ff @(posedge clk) begin
        if (reset) begin
            mip                 <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip                 <= irq_i;
            interrupt_pending_o <= mstatus[MSTATUS_MIE] && ((mie & mip) != '0)
                                   && !interrupt_ack_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mie[11] & mip[11]) begin
            interrupt_code_o <= M_EXT_INT;
        end else if (mie[3] & mip[3]) begin
            interrupt_code_o <= M_SW_INT;
        end else if (mie[7] & mip[7]) begin
            interrupt_code_o <= M_TIM_INT;
        end
    end

endmodule

// File: hdl/csr_decode.sv
// CSR decoder: splits an issued SYSTEM instruction into CSR access fields and trap events
`timescale 1ns/1ps

module csr_decode
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            instr_valid_i,
    input  logic [31:0]     instruction_i,
    input  logic [XLEN-1:0] rs1_value_i,
    output logic            csr_read_en_o,
    output logic            csr_write_en_o,
    output csr_op_e         csr_op_o,
    output logic [11:0]     csr_addr_o,
    output logic [XLEN-1:0] csr_wdata_o,
    output logic            raise_exception_o,
    output exc_code_e       exception_code_o,
    output logic            machine_return_o
);

    localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011;
    localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
    localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;

    logic [2:0] funct3;
    logic [4:0] rs1_field;
    logic       implemented;
    logic       writes;

    assign funct3     = instruction_i[14:12];
    assign rs1_field  = instruction_i[19:15];
    assign csr_addr_o = instruction_i[31:20];

    // Immediate forms carry a zero-extended 5-bit value in the rs1 field
    assign csr_wdata_o = funct3[2] ? {{(XLEN-5){1'b0}}, rs1_field} : rs1_value_i;

    // CSRRS/CSRRC with rs1 = x0 only read
    assign writes = (funct3[1:0] == 2'b01) || (rs1_field != 5'd0);

    always_comb begin
        case (csr_addr_o)
            CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
            CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET,
            CSR_MINSTRETH, CSR_CYCLE, CSR_CYCLEH, CSR_TIME, CSR_TIMEH, CSR_INSTRET,
            CSR_INSTRETH, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MHARTID: implemented = 1'b1;
            default:     implemented = 1'b0;
        endcase
    end

    always_comb begin
        csr_read_en_o     = 1'b0;
        csr_write_en_o    = 1'b0;
        csr_op_o          = CSR_NONE;
        raise_exception_o = 1'b0;
        exception_code_o  = ILLEGAL_INSTRUCTION;
        machine_return_o  = 1'b0;
        if (instr_valid_i && instruction_i[6:0] == OPC_SYSTEM) begin
            if (funct3 == 3'b000) begin
                case (instruction_i)   // Fixed encodings only
                    INSTR_ECALL: begin
                        raise_exception_o = 1'b1;
                        exception_code_o  = ECALL_M;
                    end
                    INSTR_EBREAK: begin
                        raise_exception_o = 1'b1;
                        exception_code_o  = BREAKPOINT;
                    end
                    INSTR_MRET: machine_return_o = 1'b1;
                    default:    raise_exception_o = 1'b1;
                endcase
            end else if (funct3[1:0] == 2'b00) begin
                raise_exception_o = 1'b1;   // funct3 = 100 is reserved
            end else if (!implemented || (writes && csr_addr_o[11:10] == 2'b11)) begin
                raise_exception_o = 1'b1;   // Unknown CSR or write to read-only space
            end else begin
                csr_read_en_o  = 1'b1;
                csr_write_en_o = writes;
                csr_op_o       = csr_op_e'(funct3[1:0]);
            end
        end
    end

endmodule

// File: hdl/csr_pkg.sv
// CSR unit shared types: CSR addresses, operation, cause and privilege encodings
package csr_pkg;

    // Implemented machine and user-counter CSR addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MINSTRETH = 12'hB82,
        CSR_CYCLE     = 12'hC00,   // Read-only shadows
        CSR_TIME      = 12'hC01,
        CSR_INSTRET   = 12'hC02,
        CSR_CYCLEH    = 12'hC80,
        CSR_TIMEH     = 12'hC81,
        CSR_INSTRETH  = 12'hC82,
        CSR_MVENDORID = 12'hF11,   // Machine info, all zero
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // Same order as funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [4:0] {
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        ECALL_M             = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // mstatus field positions
    localparam logic [4:0] MSTATUS_MIE    = 5'd3;
    localparam logic [4:0] MSTATUS_MPIE   = 5'd7;
    localparam logic [4:0] MSTATUS_MPP_LO = 5'd11;

endpackage

// File: hdl/csr_unit_top.sv
// CSR unit top: decoder, CSR bank, trap redirect and machine timer
`timescale 1ns/1ps

module csr_unit_top
    import csr_pkg::*;
#(
    parameter int          XLEN       = 32,
    parameter logic [31:0] TIMER_BASE = 32'h0200_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid_i,
    input  logic            instr_kill_i,
    input  logic [31:0]     instruction_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_value_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_target_i,
    input  logic            ext_irq_i,
    input  logic            sw_irq_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic            redirect_valid_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output priv_e           privilege_o,
    input  logic            psel_i,
    input  logic            penable_i,
    input  logic            pwrite_i,
    input  logic [31:0]     paddr_i,
    input  logic [31:0]     pwdata_i,
    output logic [31:0]     prdata_o,
    output logic            pready_o,
    output logic            pslverr_o
);

    logic            csr_read_en, csr_write_en, raise_exception, machine_return;
    csr_op_e         csr_op;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_wdata, mtvec, mepc;
    exc_code_e       exception_code;
    logic            interrupt_pending, interrupt_ack, timer_irq, killed;
    irq_code_e       interrupt_code;
    logic [63:0]     mtime;
    logic [31:0]     irq;

    assign killed = instr_kill_i || raise_exception;
    assign irq    = {20'b0, ext_irq_i, 3'b0, timer_irq, 3'b0, sw_irq_i, 3'b0};   // mip layout

    csr_decode #(.XLEN(XLEN)) i_csr_decode (
        .instr_valid_i(instr_valid_i), .instruction_i(instruction_i),
        .rs1_value_i(rs1_value_i), .csr_read_en_o(csr_read_en),
        .csr_write_en_o(csr_write_en), .csr_op_o(csr_op), .csr_addr_o(csr_addr),
        .csr_wdata_o(csr_wdata), .raise_exception_o(raise_exception),
        .exception_code_o(exception_code), .machine_return_o(machine_return)
    );

    csr_bank #(.XLEN(XLEN)) i_csr_bank (
        .clk(clk), .reset(reset), .read_enable_i(csr_read_en),
        .write_enable_i(csr_write_en), .operation_i(csr_op), .address_i(csr_addr),
        .data_i(csr_wdata), .killed_i(killed), .retire_i(instr_valid_i),
        .raise_exception_i(raise_exception), .exception_code_i(exception_code),
        .machine_return_i(machine_return), .pc_i(pc_i), .instruction_i(instruction_i),
        .jump_i(jump_i), .jump_target_i(jump_target_i), .mtime_i(mtime), .irq_i(irq),
        .interrupt_ack_i(interrupt_ack), .read_data_o(csr_rdata_o),
        .interrupt_pending_o(interrupt_pending), .interrupt_code_o(interrupt_code),
        .privilege_o(privilege_o), .mtvec_o(mtvec), .mepc_o(mepc)
    );

    trap_redirect #(.XLEN(XLEN)) i_trap_redirect (
        .instr_valid_i(instr_valid_i), .raise_exception_i(raise_exception),
        .exception_code_i(exception_code), .machine_return_i(machine_return),
        .interrupt_pending_i(interrupt_pending), .interrupt_code_i(interrupt_code),
        .mtvec_i(mtvec), .mepc_i(mepc), .interrupt_ack_o(interrupt_ack),
        .redirect_valid_o(redirect_valid_o), .redirect_pc_o(redirect_pc_o)
    );

    machine_timer #(.TIMER_BASE(TIMER_BASE)) i_machine_timer (
        .clk(clk), .reset(reset), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .mtime_o(mtime), .timer_irq_o(timer_irq)
    );

endmodule

// File: hdl/machine_timer.sv
// Machine timer: 64-bit mtime and mtimecmp on an APB slave port, raises the timer interrupt
`timescale 1ns/1ps

module machine_timer #(
    parameter logic [31:0] TIMER_BASE = 32'h0200_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic [63:0] mtime_o,
    output logic        timer_irq_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [31:0] offset;
    logic        hit;
    logic        access;
    logic        wr_en;

    assign offset  = paddr_i - TIMER_BASE;
    assign access  = psel_i && penable_i;
    assign wr_en   = access && pwrite_i && hit;
    assign mtime_o = mtime;

    // No wait states
    assign pready_o  = access;
    assign pslverr_o = access && !hit;

    always_comb begin
        prdata_o = '0;
        hit      = 1'b1;
        case (offset)
            32'h0:   prdata_o = mtime[31:0];
            32'h4:   prdata_o = mtime[63:32];
            32'h8:   prdata_o = mtimecmp[31:0];
            32'hC:   prdata_o = mtimecmp[63:32];
            default: hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime       <= '0;
            mtimecmp    <= '1;   // Never fires until programmed
            timer_irq_o <= 1'b0;
        end else begin
            if (wr_en && offset == 32'h0) begin
                mtime[31:0] <= pwdata_i;
            end else if (wr_en && offset == 32'h4) begin
                mtime[63:32] <= pwdata_i;
            end else begin
                mtime <= mtime + 64'd1;
            end
            if (wr_en && offset == 32'h8) begin
                mtimecmp[31:0] <= pwdata_i;
            end
            if (wr_en && offset == 32'hC) begin
                mtimecmp[63:32] <= pwdata_i;
            end
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

endmodule

// File: hdl/trap_redirect.sv
// Trap redirect: interrupt acknowledge and fetch target from mtvec or mepc
`timescale 1ns/1ps

module trap_redirect
    import csr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            instr_valid_i,
    input  logic            raise_exception_i,
    input  exc_code_e       exception_code_i,
    input  logic            machine_return_i,
    input  logic            interrupt_pending_i,
    input  irq_code_e       interrupt_code_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    output logic            interrupt_ack_o,
    output logic            redirect_valid_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic [XLEN-1:0] tvec_base;
    logic [XLEN-1:0] vector_offset;

    // Interrupt taken on an issued instruction unless it traps itself
    assign interrupt_ack_o = interrupt_pending_i && instr_valid_i && !raise_exception_i;

    assign tvec_base = {mtvec_i[XLEN-1:2], 2'b00};

    // Vectored mode applies to interrupts only
    assign vector_offset = (mtvec_i[0] && !raise_exception_i)
                           ? {{(XLEN-7){1'b0}}, interrupt_code_i, 2'b00} : '0;

    assign redirect_valid_o = machine_return_i || raise_exception_i || interrupt_ack_o;
    assign redirect_pc_o    = machine_return_i ? mepc_i : tvec_base + vector_offset;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_csr_unit -f all.f -o sim_csr_unit

# Keep running after an assertion failure so the testbench reaches its summary
./obj_dir/sim_csr_unit +verilator+error+limit+1000 | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: sim/csr_unit_sva.sv
// CSR unit checker: redirect alignment, APB response rules and privilege after a redirect
`timescale 1ns/1ps

module csr_unit_sva
    import csr_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        redirect_valid_i,
    input logic [31:0] redirect_pc_i,
    input priv_e       privilege_i,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pready_i,
    input logic        pslverr_i
);

    int fail_count = 0;   // Read by the testbench at the end of the run

    redirect_aligned: assert property (@(posedge clk) disable iff (reset)
        redirect_valid_i |-> redirect_pc_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("redirect target is not word aligned");
        end

    // Slave error only while an access phase is open
    slverr_in_access: assert property (@(posedge clk) disable iff (reset)
        pslverr_i |-> psel_i && penable_i)
        else begin
            fail_count++;
            $error("pslverr outside an access phase");
        end

    ready_in_access: assert property (@(posedge clk) disable iff (reset)
        psel_i && penable_i |-> pready_i)
        else begin
            fail_count++;
            $error("access phase without pready");
        end

    machine_after_redirect: assert property (@(posedge clk) disable iff (reset)
        redirect_valid_i |=> privilege_i == PRIV_M)
        else begin
            fail_count++;
            $error("privilege not machine after a redirect");
        end

endmodule

bind csr_unit_top csr_unit_sva i_csr_unit_sva (
    .clk(clk), .reset(reset), .redirect_valid_i(redirect_valid_o),
    .redirect_pc_i(redirect_pc_o), .privilege_i(privilege_o), .psel_i(psel_i),
    .penable_i(penable_i), .pready_i(pready_o), .pslverr_i(pslverr_o)
);

// File: sim/tb_csr_unit.sv
// Testbench for the CSR unit: CSR access, traps, interrupts, counters and the timer APB port
`timescale 1ns/1ps

module tb_csr_unit
    import csr_pkg::*;
();

    localparam logic [31:0] TIMER_BASE = 32'h0200_0000;
    localparam logic [31:0] NOP        = 32'h0000_0013;   // addi x0, x0, 0
    localparam logic [31:0] ECALL      = 32'h0000_0073;
    localparam logic [31:0] MRET       = 32'h3020_0073;

    logic        clk, reset, instr_valid, instr_kill, jump, ext_irq, sw_irq;
    logic [31:0] instruction, pc, rs1_value, jump_target;
    logic        psel, penable, pwrite, pready, pslverr, redirect_valid;
    logic [31:0] paddr, pwdata, prdata, csr_rdata, redirect_pc;
    priv_e       privilege;

    logic [31:0] rng_state = 32'd59;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] seen_rdata, seen_target, value, first, tvec, instr, src;
    logic        seen_redirect, apb_err;
    logic [11:0] addrs [3];
    logic [31:0] model [3];
    logic [2:0]  funct3;
    int          a, k, n;

    csr_unit_top #(.XLEN(32), .TIMER_BASE(TIMER_BASE)) i_csr_unit_top (
        .clk(clk), .reset(reset), .instr_valid_i(instr_valid), .instr_kill_i(instr_kill),
        .instruction_i(instruction), .pc_i(pc), .rs1_value_i(rs1_value), .jump_i(jump),
        .jump_target_i(jump_target), .ext_irq_i(ext_irq), .sw_irq_i(sw_irq),
        .csr_rdata_o(csr_rdata), .redirect_valid_o(redirect_valid),
        .redirect_pc_o(redirect_pc), .privilege_o(privilege), .psel_i(psel),
        .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [11:0] addr);
        return {addr, rs1, f3, rd, 7'b1110011};
    endfunction

    // Expected register value after a write, set or clear
    function automatic logic [31:0] csr_update(input logic [1:0] op, input logic [31:0] old,
                                               input logic [31:0] data, input logic [11:0] addr);
        logic [31:0] mask;
        logic [31:0] result;
        case (addr)
            CSR_MSTATUS: mask = 32'h007E_19AA;
            CSR_MIE:     mask = 32'h0000_0888;
            default:     mask = 32'hFFFF_FFFF;
        endcase
        case (op)
            2'b01:   result = data;
            2'b10:   result = old | data;
            default: result = old & ~data;
        endcase
        return (result & mask) | (old & ~mask);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One issue cycle; combinational outputs are captured mid-cycle
    task automatic issue(input logic [31:0] word, input logic [31:0] rs1v, input logic kill);
        instr_valid = 1'b1;
        instr_kill  = kill;
        instruction = word;
        rs1_value   = rs1v;
        #1;
        seen_rdata    = csr_rdata;
        seen_redirect = redirect_valid;
        seen_target   = redirect_pc;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr_kill  = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        issue(csr_instr(3'b010, 5'd1, 5'd0, addr), 32'd0, 1'b0);
        data = seen_rdata;
    endtask

    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        int wait_cycles;
        psel    = 1'b1;   // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable     = 1'b1;
        wait_cycles = 0;
        #1;
        while (!pready && wait_cycles < 20) begin
            @(posedge clk);
            #2;
            wait_cycles++;
        end
        if (!pready) begin
            timeouts++;
            $display("Timeout: APB access to %h never got pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Keeps issuing NOPs until an interrupt redirect shows up
    task automatic wait_redirect();
        int cycles;
        cycles        = 0;
        seen_redirect = 1'b0;
        while (!seen_redirect && cycles < 60) begin
            issue(NOP, 32'd0, 1'b0);
            cycles++;
        end
        if (!seen_redirect) begin
            timeouts++;
            $display("Timeout: no interrupt redirect arrived while instructions issued");
        end
    endtask

    initial begin
        reset = 1'b1;
        {instr_valid, instr_kill, jump, ext_irq, sw_irq} = '0;
        {instruction, rs1_value, jump_target, paddr, pwdata} = '0;
        {psel, penable, pwrite} = '0;
        pc = 32'h0000_0100;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // CSR write, set and clear in register and immediate forms
        addrs = '{CSR_MSCRATCH, CSR_MIE, CSR_MSTATUS};
        model = '{32'h0, 32'h0, 32'h0000_1800};
        for (a = 0; a < 3; a++) begin
            for (k = 0; k < 7; k++) begin
                funct3 = (k % 6 < 3) ? 3'(k % 6 + 1) : 3'(k % 6 + 2);
                src    = xorshift();
                issue(csr_instr(funct3, 5'd2, src[4:0], addrs[a]), src, k == 6);   // Last is killed
                check_value("old CSR value", seen_rdata, model[a]);
                if (k != 6 && (funct3[1:0] == 2'b01 || src[4:0] != 5'd0)) begin
                    model[a] = csr_update(funct3[1:0], model[a],
                                          funct3[2] ? {27'd0, src[4:0]} : src, addrs[a]);
                end
            end
            csr_read(addrs[a], value);
            check_value("final CSR value", value, model[a]);
        end
        issue(csr_instr(3'b001, 5'd0, 5'd0, CSR_MIE), 32'd0, 1'b0);
        issue(csr_instr(3'b001, 5'd0, 5'd1, CSR_MSTATUS), 32'h0000_0008, 1'b0);   // MIE only

        // ECALL and MRET
        tvec = xorshift() & 32'hFFFF_FFFC;
        issue(csr_instr(3'b001, 5'd0, 5'd3, CSR_MTVEC), tvec, 1'b0);
        first = xorshift() & 32'hFFFF_FFFC;
        pc    = first;
        issue(ECALL, 32'd0, 1'b0);
        check_value("ECALL redirect", {31'd0, seen_redirect}, 32'd1);
        check_value("ECALL target", seen_target, tvec);
        csr_read(CSR_MEPC, value);
        check_value("mepc after ECALL", value, first);
        csr_read(CSR_MCAUSE, value);
        check_value("mcause after ECALL", value, 32'd11);
        check_value("privilege", {30'd0, privilege}, {30'd0, PRIV_M});
        issue(MRET, 32'd0, 1'b0);
        check_value("MRET target", seen_target, first);
        csr_read(CSR_MSTATUS, value);
        check_value("MIE after MRET", {31'd0, value[3]}, 32'd1);

        // Write to a read-only CSR
        first = xorshift() & 32'hFFFF_FFFC;
        pc    = first;
        instr = csr_instr(3'b001, 5'd4, 5'd7, CSR_MVENDORID);
        issue(instr, xorshift(), 1'b0);
        check_value("illegal target", seen_target, tvec);
        csr_read(CSR_MCAUSE, value);
        check_value("mcause after illegal", value, 32'd2);
        csr_read(CSR_MEPC, value);
        check_value("mepc after illegal", value, first + 32'd4);
        csr_read(CSR_MTVAL, value);
        check_value("mtval after illegal", value, instr);
        csr_read(CSR_MVENDORID, value);
        check_value("mvendorid", value, 32'd0);

        // Timer interrupt through vectored mtvec
        issue(csr_instr(3'b001, 5'd0, 5'd3, CSR_MTVEC), tvec | 32'd1, 1'b0);
        issue(csr_instr(3'b001, 5'd0, 5'd3, CSR_MIE), 32'h0000_0080, 1'b0);
        apb_access(1'b0, TIMER_BASE, 32'd0, value, apb_err);
        apb_access(1'b1, TIMER_BASE + 32'd12, 32'd0, first, apb_err);
        apb_access(1'b1, TIMER_BASE + 32'd8, value + 32'd30, first, apb_err);
        issue(csr_instr(3'b110, 5'd0, 5'd8, CSR_MSTATUS), 32'd0, 1'b0);   // csrsi MIE
        wait_redirect();
        check_value("timer vector", seen_target, tvec + 32'd28);
        csr_read(CSR_MCAUSE, value);
        check_value("mcause after timer", value, 32'h8000_0007);

        // External wins over software and timer
        ext_irq = 1'b1;
        sw_irq  = 1'b1;
        issue(csr_instr(3'b001, 5'd0, 5'd3, CSR_MIE), 32'h0000_0888, 1'b0);
        issue(csr_instr(3'b110, 5'd0, 5'd8, CSR_MSTATUS), 32'd0, 1'b0);
        wait_redirect();
        check_value("external vector", seen_target, tvec + 32'd44);
        csr_read(CSR_MCAUSE, value);
        check_value("mcause after external", value, 32'h8000_000B);
        ext_irq = 1'b0;
        sw_irq  = 1'b0;
        issue(csr_instr(3'b001, 5'd0, 5'd0, CSR_MIE), 32'd0, 1'b0);

        // Counters
        n = 5 + int'(xorshift() % 32'd8);
        csr_read(CSR_MCYCLE, first);
        repeat (n - 1) issue(NOP, 32'd0, 1'b0);
        csr_read(CSR_MCYCLE, value);
        check_value("mcycle delta", value - first, 32'(n));
        csr_read(CSR_MINSTRET, first);
        for (k = 0; k < 2 * n; k++) begin
            issue(NOP, 32'd0, k[0]);   // Every second one killed
        end
        csr_read(CSR_MINSTRET, value);
        check_value("minstret delta", value - first, 32'(n + 1));

        // Timer register port
        src = xorshift();
        apb_access(1'b1, TIMER_BASE + 32'd8, src, value, apb_err);
        check_value("pslverr on mtimecmp write", {31'd0, apb_err}, 32'd0);
        apb_access(1'b0, TIMER_BASE + 32'd8, 32'd0, value, apb_err);
        check_value("mtimecmp readback", value, src);
        apb_access(1'b0, TIMER_BASE + 32'd16, 32'd0, value, apb_err);
        check_value("pslverr on unmapped offset", {31'd0, apb_err}, 32'd1);

        n = i_csr_unit_top.i_csr_unit_sva.fail_count;
        $display("Value errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, n, timeouts);
        if (errors == 0 && n == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
